/* common/geom_pkg.sv */
package geom_pkg;

    localparam int num_slots = 32;
    localparam int slot_w    = 5;

    typedef logic signed [15:0] coord_t;
    typedef logic signed [7:0]  coeff_t;

    // x sits in the low half, as in the video memory layout
    typedef struct packed {
        coord_t y;
        coord_t x;
    } vertex_t;

    // value + 1 is the vertex count
    typedef enum logic [1:0] {
        type_point = 2'd0,
        type_line  = 2'd1,
        type_tri   = 2'd2,
        type_quad  = 2'd3
    } obj_type_t;

    typedef struct packed {
        obj_type_t         obj_type;
        logic [5:0]        rsvd;     // always zero
        logic [7:0]        color;
        vertex_t [3:0]     v;
    } obj_rec_t;

    typedef enum logic [3:0] {
        op_create    = 4'h0,
        op_delete    = 4'h1,
        op_trans_one = 4'h3,
        op_trans_all = 4'h4,
        op_scale     = 4'h5,
        op_rot_left  = 4'h6,
        op_rot_right = 4'h7,
        op_loadback  = 4'hf
    } gmt_op_t;

    typedef union packed {
        struct packed {
            logic [1:0] point;
            logic       move_y;
            logic       move_x;
        } pick;
        struct packed {
            logic       pad;
            logic [2:0] amount;
        } amt;
    } gmt_code_u;

    typedef struct packed {
        gmt_op_t           op;
        gmt_code_u         code;
        logic [slot_w-1:0] obj_num;
        obj_type_t         obj_type;
        logic [7:0]        color;
        vertex_t [3:0]     v;
    } cmd_t;

    typedef struct packed {
        coeff_t c1;
        coeff_t c2;
        coeff_t c3;
        coeff_t c4;
    } coeff_set_t;

    // scale factors 1/2, 3/4, 3/2, 2/1
    localparam coeff_t scale_num [4] = '{1, 3, 3, 2};
    localparam coeff_t scale_den [4] = '{2, 4, 2, 1};

    localparam coeff_t rot_div = 100;

    // cos and sin times 100, steps of 45 degrees
    localparam coeff_t rot_cos [8] = '{100, 71, 0, -71, -100, -71, 0, 71};
    localparam coeff_t rot_sin [8] = '{0, 71, 100, 71, 0, -71, -100, -71};

endpackage

/* geom_xform.f */
+incdir+testbench
common/geom_pkg.sv
src/coeff_rom.sv
src/object_store.sv
matrix_unit/matrix_ctrl.sv
matrix_unit/vertex_counter.sv
matrix_unit/vertex_alu.sv
src/geom_xform_top.sv
testbench/tb_geom_xform.sv

/* matrix_unit/matrix_ctrl.sv */
`timescale 1ns/1ps

module matrix_ctrl import geom_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              go,
    input  cmd_t              cmd,
    input  logic              addr_vld,
    input  logic              slot_used,
    input  logic              mem_full,
    input  logic              last,
    output logic              busy,
    output logic              crt_obj,
    output logic              del_obj,
    output logic              ref_addr,
    output logic [slot_w-1:0] obj_num,
    output logic              rd_en,
    output logic              wr_en,
    output logic              ld_obj,
    output logic              ld_new,
    output logic              calc_centroid,
    output logic              ld_coeff,
    output logic              cnt_clear,
    output logic              step,
    output logic              writeback,
    output logic              rd_vld,
    output logic [3:0]        coeff_addr
);

    typedef enum logic [2:0] {
        st_idle, st_wait_rd, st_load, st_centroid,
        st_xform, st_wb, st_wait_wr, st_loadback
    } state_t;

    typedef struct packed {
        logic create;
        logic del;
        logic trans;
        logic ldback;
    } kind_t;

    state_t state, nxt_state;
    kind_t  kind_d, kind_q;

    assign busy       = (state != st_idle);
    assign obj_num    = cmd.obj_num;   // cpu holds cmd until busy falls
    assign coeff_addr = {cmd.op == op_rot_right, cmd.code.amt.amount};

    always_comb begin
        kind_d.create = (cmd.op == op_create);
        kind_d.del    = (cmd.op == op_delete);
        kind_d.trans  = (cmd.op == op_trans_one) || (cmd.op == op_trans_all);
        kind_d.ldback = (cmd.op == op_loadback);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            kind_q <= '0;
        end else begin
            state <= nxt_state;
            if (state == st_idle && go) begin
                kind_q <= kind_d;   // op decoded once here
            end
        end
    end

    always_comb begin
        nxt_state     = state;
        crt_obj       = 1'b0;
        del_obj       = 1'b0;
        ref_addr      = 1'b0;
        rd_en         = 1'b0;
        wr_en         = 1'b0;
        ld_obj        = 1'b0;
        ld_new        = 1'b0;
        calc_centroid = 1'b0;
        ld_coeff      = 1'b0;
        cnt_clear     = 1'b0;
        step          = 1'b0;
        writeback     = 1'b0;
        rd_vld        = 1'b0;
        case (state)
            st_idle: begin
                if (go) begin
                    case (cmd.op)
                        op_create: begin
                            if (!mem_full) begin   // dropped when full
                                crt_obj   = 1'b1;
                                nxt_state = st_load;
                            end
                        end
                        op_delete: begin
                            del_obj   = 1'b1;
                            nxt_state = st_wait_wr;
                        end
                        op_trans_one, op_trans_all, op_scale,
                        op_rot_left, op_rot_right, op_loadback: begin
                            ref_addr  = 1'b1;
                            nxt_state = st_wait_rd;
                        end
                        default: ;   // no-op codes
                    endcase
                end
            end
            st_wait_rd: begin
                if (addr_vld && slot_used) begin
                    rd_en     = 1'b1;
                    nxt_state = kind_q.ldback ? st_loadback : st_load;
                end else begin
                    nxt_state = st_idle;   // free slot, nothing to do
                end
            end
            st_load: begin
                if (kind_q.create) begin
                    ld_new    = 1'b1;
                    nxt_state = st_wb;
                end else begin
                    ld_obj    = 1'b1;
                    ld_coeff  = 1'b1;
                    cnt_clear = 1'b1;
                    nxt_state = kind_q.trans ? st_xform : st_centroid;
                end
            end
            st_centroid: begin
                calc_centroid = 1'b1;
                nxt_state     = st_xform;
            end
            st_xform: begin
                step = 1'b1;   // one vertex per cycle
                if (last) begin
                    nxt_state = st_wb;
                end
            end
            st_wb: begin
                writeback = 1'b1;
                nxt_state = st_wait_wr;
            end
            st_wait_wr: begin
                wr_en     = !(kind_q.del || kind_q.ldback);
                nxt_state = st_idle;
            end
            st_loadback: begin
                rd_vld    = 1'b1;   // record sits on obj_in now
                nxt_state = st_wait_wr;
            end
            default: nxt_state = st_idle;
        endcase
    end

endmodule

/* matrix_unit/vertex_alu.sv */
`timescale 1ns/1ps

module vertex_alu import geom_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cmd_t       cmd,
    input  obj_rec_t   obj_in,
    input  logic       ld_obj,
    input  logic       ld_new,
    input  logic       calc_centroid,
    input  logic       ld_coeff,
    input  coeff_set_t coeffs,
    input  logic       step,
    input  logic [1:0] index,
    input  logic       active,
    input  logic       writeback,
    output obj_rec_t   obj_out
);

    obj_rec_t          work;
    vertex_t           cen;
    coeff_set_t        kset;
    coeff_t            den;
    vertex_t           off;
    vertex_t           cur, dif, nxt_v;
    logic signed [17:0] sum_x, sum_y;
    logic signed [3:0]  n_vert;

    // truncates toward zero, wraps to 16 bits
    function automatic coord_t mul_div(coord_t d, coeff_t c, coeff_t q);
        logic signed [31:0] p;
        p = d * c;
        p = p / q;
        return p[15:0];
    endfunction

    always_comb begin
        n_vert = $signed({2'b00, work.obj_type}) + 4'sd1;
        sum_x  = '0;
        sum_y  = '0;
        for (int i = 0; i < 4; i++) begin
            if (i <= int'(work.obj_type)) begin
                sum_x = sum_x + work.v[i].x;
                sum_y = sum_y + work.v[i].y;
            end
        end
    end

    always_comb begin
        cur     = work.v[index];
        dif.x   = cur.x - cen.x;
        dif.y   = cur.y - cen.y;
        nxt_v.x = cen.x + mul_div(dif.x, kset.c1, den) + mul_div(dif.y, kset.c2, den) + off.x;
        nxt_v.y = cen.y + mul_div(dif.x, kset.c3, den) + mul_div(dif.y, kset.c4, den) + off.y;
    end

    always_ff @(posedge clk) begin
        if (ld_new) begin
            work.obj_type <= cmd.obj_type;
            work.rsvd     <= '0;
            work.color    <= cmd.color;
            for (int i = 0; i < 4; i++) begin
                work.v[i] <= (i <= int'(cmd.obj_type)) ? cmd.v[i] : '0;   // unused vertices zero
            end
        end else if (ld_obj) begin
            work <= obj_in;
        end else if (step && active) begin
            work.v[index] <= nxt_v;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen     <= '0;
            kset    <= '0;
            den     <= 8'sd1;
            off     <= '0;
            obj_out <= '0;
        end else begin
            if (ld_coeff) begin
                case (cmd.op)
                    op_scale: begin
                        kset <= '{scale_num[cmd.code.amt.amount[1:0]], 8'sd0, 8'sd0,
                                  scale_num[cmd.code.amt.amount[1:0]]};
                        den  <= scale_den[cmd.code.amt.amount[1:0]];
                        off  <= '0;
                    end
                    op_rot_left, op_rot_right: begin
                        kset <= coeffs;
                        den  <= rot_div;
                        off  <= '0;
                    end
                    default: begin   // translate, identity plus offset
                        kset  <= '{8'sd1, 8'sd0, 8'sd0, 8'sd1};
                        den   <= 8'sd1;
                        off.x <= cmd.code.pick.move_x ? cmd.v[0].x : '0;
                        off.y <= cmd.code.pick.move_y ? cmd.v[0].y : '0;
                    end
                endcase
            end
            if (calc_centroid) begin
                cen.x <= coord_t'(sum_x / n_vert);
                cen.y <= coord_t'(sum_y / n_vert);
            end
            if (writeback) begin
                obj_out <= work;
            end
        end
    end

endmodule

/* matrix_unit/vertex_counter.sv */
`timescale 1ns/1ps

module vertex_counter import geom_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       step,
    input  obj_type_t  obj_type,
    input  logic       single,
    input  logic [1:0] pick,
    output logic [1:0] index,
    output logic       last,
    output logic       active
);

    // type code equals vertex count minus one
    assign last   = (index == 2'(obj_type));
    assign active = !single || (index == pick);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (step && !last) begin
            index <= index + 2'd1;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the geom_xform testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_geom_xform \
    -f geom_xform.f -o sim_geom_xform

./obj_dir/sim_geom_xform > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* src/coeff_rom.sv */
`timescale 1ns/1ps

module coeff_rom import geom_pkg::*; (
    input  logic       clk,
    input  logic [3:0] addr,
    output coeff_t     c1,
    output coeff_t     c2,
    output coeff_t     c3,
    output coeff_t     c4
);

    logic [2:0] angle;
    coeff_t     cos_v;
    coeff_t     sin_v;

    assign angle = addr[2:0];
    assign cos_v = rot_cos[angle];

    // upper half of the table is the clockwise set
    assign sin_v = addr[3] ? -rot_sin[angle] : rot_sin[angle];

    // rotation matrix
    //   | cos  -sin |
    //   | sin   cos |
    always_ff @(posedge clk) begin
        c1 <= cos_v;
        c2 <= -sin_v;
        c3 <= sin_v;
        c4 <= cos_v;
    end

endmodule

/* src/geom_xform_top.sv */
`timescale 1ns/1ps

module geom_xform_top import geom_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              go,
    input  cmd_t              cmd,
    output logic              busy,
    output logic [slot_w-1:0] lst_stored_obj,
    output logic              obj_mem_full,
    output obj_rec_t          obj_rd_data,
    output logic              obj_rd_vld
);

    logic              crt_obj, del_obj, ref_addr, rd_en, wr_en;
    logic [slot_w-1:0] obj_num;
    logic              addr_vld, slot_used;
    logic              ld_obj, ld_new, calc_centroid, ld_coeff;
    logic              cnt_clear, step, writeback;
    logic [3:0]        coeff_addr;
    logic [1:0]        index;
    logic              last, active;
    coeff_t            rom_c1, rom_c2, rom_c3, rom_c4;
    obj_rec_t          obj_out;

    matrix_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n), .go(go), .cmd(cmd),
        .addr_vld(addr_vld), .slot_used(slot_used), .mem_full(obj_mem_full), .last(last),
        .busy(busy), .crt_obj(crt_obj), .del_obj(del_obj), .ref_addr(ref_addr),
        .obj_num(obj_num), .rd_en(rd_en), .wr_en(wr_en), .ld_obj(ld_obj), .ld_new(ld_new),
        .calc_centroid(calc_centroid), .ld_coeff(ld_coeff), .cnt_clear(cnt_clear),
        .step(step), .writeback(writeback), .rd_vld(obj_rd_vld), .coeff_addr(coeff_addr)
    );

    // vertex count comes from the record read out of the store
    vertex_counter cnt_i (
        .clk(clk), .rst_n(rst_n), .clear(cnt_clear), .step(step),
        .obj_type(obj_rd_data.obj_type), .single(cmd.op == op_trans_one),
        .pick(cmd.code.pick.point), .index(index), .last(last), .active(active)
    );

    vertex_alu alu_i (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .obj_in(obj_rd_data),
        .ld_obj(ld_obj), .ld_new(ld_new), .calc_centroid(calc_centroid),
        .ld_coeff(ld_coeff), .coeffs({rom_c1, rom_c2, rom_c3, rom_c4}),
        .step(step), .index(index), .active(active), .writeback(writeback),
        .obj_out(obj_out)
    );

    coeff_rom rom_i (
        .clk(clk), .addr(coeff_addr),
        .c1(rom_c1), .c2(rom_c2), .c3(rom_c3), .c4(rom_c4)
    );

    object_store store_i (
        .clk(clk), .rst_n(rst_n), .crt_obj(crt_obj), .del_obj(del_obj),
        .ref_addr(ref_addr), .obj_num(obj_num), .rd_en(rd_en), .wr_en(wr_en),
        .obj_out(obj_out), .addr_vld(addr_vld), .lst_stored_obj(lst_stored_obj),
        .obj_mem_full(obj_mem_full), .slot_used(slot_used), .obj_in(obj_rd_data)
    );

endmodule

/* src/object_store.sv */
`timescale 1ns/1ps

module object_store import geom_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              crt_obj,
    input  logic              del_obj,
    input  logic              ref_addr,
    input  logic [slot_w-1:0] obj_num,
    input  logic              rd_en,
    input  logic              wr_en,
    input  obj_rec_t          obj_out,
    output logic              addr_vld,
    output logic [slot_w-1:0] lst_stored_obj,
    output logic              obj_mem_full,
    output logic              slot_used,
    output obj_rec_t          obj_in
);

    logic [num_slots-1:0] used;
    logic [num_slots-1:0] alloc_mask;
    logic [slot_w-1:0]    free_slot;
    logic [slot_w-1:0]    addr_q;   // slot of the current command

    obj_rec_t mem [num_slots];

    // lowest free slot wins
    always_comb begin
        free_slot = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_slot = slot_w'(i);
            end
        end
    end

    assign alloc_mask = num_slots'(1) << free_slot;
    assign slot_used  = used[addr_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used           <= '0;
            addr_q         <= '0;
            addr_vld       <= 1'b0;
            lst_stored_obj <= '0;
            obj_mem_full   <= 1'b0;
        end else begin
            addr_vld <= crt_obj | ref_addr;   // fixed one-cycle answer
            if (crt_obj) begin
                used           <= used | alloc_mask;
                addr_q         <= free_slot;
                lst_stored_obj <= free_slot;
                obj_mem_full   <= &(used | alloc_mask);
            end else if (del_obj) begin
                used[obj_num] <= 1'b0;
                obj_mem_full  <= 1'b0;   // at least one slot free now
            end else if (ref_addr) begin
                addr_q <= obj_num;
            end
        end
    end

    // record array, synchronous read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr_q] <= obj_out;
        end
        if (rd_en) begin
            obj_in <= mem[addr_q];
        end
    end

endmodule

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

obj_rec_t    model_mem [32];
logic [31:0] model_used;
int          model_last;

// rotation table, cos and sin times 100 in steps of 45 degrees
localparam int model_cos [8] = '{100, 71, 0, -71, -100, -71, 0, 71};
localparam int model_sin [8] = '{0, 71, 100, 71, 0, -71, -100, -71};
localparam int model_num [4] = '{1, 3, 3, 2};
localparam int model_den [4] = '{2, 4, 2, 1};

function automatic int lowest_free();
    for (int i = 0; i < 32; i++) begin
        if (!model_used[i]) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic int pick_used();
    int start;
    start = $urandom_range(0, 31);
    for (int i = 0; i < 32; i++) begin
        if (model_used[(start + i) % 32]) begin
            return (start + i) % 32;
        end
    end
    return 0;
endfunction

function automatic obj_rec_t new_record(cmd_t c);
    obj_rec_t r;
    r.obj_type = c.obj_type;
    r.rsvd     = '0;
    r.color    = c.color;
    for (int i = 0; i < 4; i++) begin
        r.v[i] = (i <= int'(c.obj_type)) ? c.v[i] : '0;   // unused vertices zero
    end
    return r;
endfunction

function automatic coord_t wrap16(int a);
    return a[15:0];
endfunction

function automatic obj_rec_t model_xform(obj_rec_t r, cmd_t c);
    obj_rec_t o;
    int       n, a, sx, sy, cx, cy, ox, oy, q, sn, dx, dy;
    int       k [4];
    o  = r;
    n  = int'(r.obj_type) + 1;
    a  = int'(c.code.amt.amount);
    sx = 0;
    sy = 0;
    for (int i = 0; i < n; i++) begin
        sx = sx + int'(r.v[i].x);
        sy = sy + int'(r.v[i].y);
    end
    cx = sx / n;   // truncates toward zero
    cy = sy / n;
    ox = 0;
    oy = 0;
    q  = 1;
    k  = '{1, 0, 0, 1};
    case (c.op)
        op_scale: begin
            k = '{model_num[a % 4], 0, 0, model_num[a % 4]};
            q = model_den[a % 4];
        end
        op_rot_left, op_rot_right: begin
            sn = (c.op == op_rot_right) ? -model_sin[a] : model_sin[a];
            k  = '{model_cos[a], -sn, sn, model_cos[a]};
            q  = 100;
        end
        default: begin   // translate, plain offset
            cx = 0;
            cy = 0;
            ox = c.code.pick.move_x ? int'(c.v[0].x) : 0;
            oy = c.code.pick.move_y ? int'(c.v[0].y) : 0;
        end
    endcase
    for (int i = 0; i < n; i++) begin
        if (c.op != op_trans_one || i == int'(c.code.pick.point)) begin
            dx = int'(wrap16(int'(r.v[i].x) - cx));
            dy = int'(wrap16(int'(r.v[i].y) - cy));
            o.v[i].x = wrap16(cx + dx * k[0] / q + dy * k[1] / q + ox);
            o.v[i].y = wrap16(cy + dx * k[2] / q + dy * k[3] / q + oy);
        end
    end
    return o;
endfunction

`endif

/* testbench/tb_geom_xform.sv */
`timescale 1ns/1ps

module tb_geom_xform import geom_pkg::*; ();

    localparam int timeout_cycles = 200;

    logic              clk;
    logic              rst_n;
    logic              go;
    cmd_t              cmd;
    logic              busy;
    logic [slot_w-1:0] lst_stored_obj;
    logic              obj_mem_full;
    obj_rec_t          obj_rd_data;
    logic              obj_rd_vld;

    int checks;
    int errors;
    int checks_at_start;
    int errors_at_start;

    `include "tb_model.svh"

    geom_xform_top dut_i (
        .clk(clk), .rst_n(rst_n), .go(go), .cmd(cmd),
        .busy(busy), .lst_stored_obj(lst_stored_obj), .obj_mem_full(obj_mem_full),
        .obj_rd_data(obj_rd_data), .obj_rd_vld(obj_rd_vld)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - checks_at_start, errors - errors_at_start);
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    function automatic cmd_t rand_cmd(input gmt_op_t op, input int slot);
        cmd_t c;
        c.op       = op;
        c.code     = gmt_code_u'(4'($urandom));
        c.obj_num  = slot_w'(slot);
        c.obj_type = obj_type_t'(2'($urandom));
        c.color    = 8'($urandom);
        for (int i = 0; i < 4; i++) begin
            c.v[i].x = 16'($urandom_range(0, 4000) - 2000);
            c.v[i].y = 16'($urandom_range(0, 4000) - 2000);
        end
        return c;
    endfunction

    // called 2 ns after a rising edge, returns once busy is low again
    task automatic run_cmd(input cmd_t c, output logic rose, output logic vld_seen,
                           output obj_rec_t rec);
        int cycles;
        cmd = c;
        go  = 1'b1;
        @(posedge clk);
        #2;
        go       = 1'b0;
        rose     = busy;
        vld_seen = 1'b0;
        rec      = '0;
        cycles   = 0;
        while (busy && cycles < timeout_cycles) begin
            if (obj_rd_vld) begin
                vld_seen = 1'b1;
                rec      = obj_rd_data;
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        if (busy) begin
            $display("timeout: busy still high %0d cycles after op %h", cycles, c.op);
            $display("*** TEST FAILED ***");
            $finish;
        end
    endtask

    task automatic check_slot(input int s);
        cmd_t     c;
        logic     rose;
        logic     vld;
        obj_rec_t rec;
        c = rand_cmd(op_loadback, s);
        run_cmd(c, rose, vld, rec);
        check_value($sformatf("obj_rd_vld slot %0d", s), 160'(vld), 160'(model_used[s]));
        if (model_used[s]) begin
            check_value($sformatf("obj_rd_data slot %0d", s), 160'(rec), 160'(model_mem[s]));
        end
    endtask

    task automatic create_one();
        cmd_t     c;
        logic     rose;
        logic     vld;
        obj_rec_t rec;
        int       s;
        c = rand_cmd(op_create, 0);
        s = lowest_free();
        run_cmd(c, rose, vld, rec);
        check_value("busy on create", 160'(rose), 160'(s >= 0));   // dropped when full
        if (s >= 0) begin
            model_used[s] = 1'b1;
            model_mem[s]  = new_record(c);
            model_last    = s;
        end
        check_value("lst_stored_obj", 160'(lst_stored_obj), 160'(model_last[4:0]));
        check_value("obj_mem_full", 160'(obj_mem_full), 160'(&model_used));
    endtask

    task automatic delete_one(input int s);
        cmd_t     c;
        logic     rose;
        logic     vld;
        obj_rec_t rec;
        c = rand_cmd(op_delete, s);
        run_cmd(c, rose, vld, rec);
        check_value("busy on delete", 160'(rose), 160'(1));
        model_used[s] = 1'b0;
        check_value("obj_mem_full", 160'(obj_mem_full), 160'(&model_used));
    endtask

    task automatic apply_cmd(input cmd_t c);
        logic     rose;
        logic     vld;
        obj_rec_t rec;
        int       s;
        s = int'(c.obj_num);
        run_cmd(c, rose, vld, rec);
        check_value("busy on transform", 160'(rose), 160'(1));
        check_value("obj_rd_vld on transform", 160'(vld), 160'(0));
        if (model_used[s]) begin
            model_mem[s] = model_xform(model_mem[s], c);
        end
        check_slot(s);
    endtask

    initial begin
        cmd_t     c;
        logic     rose;
        logic     vld;
        obj_rec_t rec;
        int       s;
        int       dead [3];
        gmt_op_t  noops [8];
        clk             = 1'b0;
        rst_n           = 1'b0;
        go              = 1'b0;
        cmd             = '0;
        checks          = 0;
        errors          = 0;
        checks_at_start = 0;
        errors_at_start = 0;
        model_used      = '0;
        model_last      = 0;
        noops = '{gmt_op_t'(4'h2), gmt_op_t'(4'h8), gmt_op_t'(4'h9), gmt_op_t'(4'ha),
                  gmt_op_t'(4'hb), gmt_op_t'(4'hc), gmt_op_t'(4'hd), gmt_op_t'(4'he)};
        void'($urandom(32'he51af989));

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_value("busy after reset", 160'(busy), 160'(0));
        check_value("obj_rd_vld after reset", 160'(obj_rd_vld), 160'(0));
        check_value("obj_mem_full after reset", 160'(obj_mem_full), 160'(0));

        // creates land in the lowest free slots
        for (int i = 0; i < 12; i++) begin
            create_one();
        end
        for (int i = 0; i < 12; i++) begin
            check_slot(i);
        end
        report_test(1, "create");

        while (lowest_free() >= 0) begin
            create_one();
        end
        create_one();   // 33rd, store full
        s = $urandom_range(0, 31);
        delete_one(s);
        create_one();   // refills the freed slot
        check_slot(s);
        report_test(2, "store full");

        for (int i = 0; i < 16; i++) begin
            c = rand_cmd(($urandom_range(0, 1) == 0) ? op_trans_one : op_trans_all, pick_used());
            apply_cmd(c);
        end
        report_test(3, "translate");

        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 32; i++) begin
                if (int'(model_mem[i].obj_type) == t) begin
                    c = rand_cmd(op_scale, i);
                    apply_cmd(c);
                    break;
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            apply_cmd(rand_cmd(op_scale, pick_used()));
        end
        report_test(4, "scale");

        for (int a = 0; a < 8; a++) begin
            c = rand_cmd(op_rot_left, pick_used());
            c.code.amt.amount = 3'(a);
            apply_cmd(c);
            c = rand_cmd(op_rot_right, pick_used());
            c.code.amt.amount = 3'(a);
            apply_cmd(c);
        end
        report_test(5, "rotate");

        for (int i = 0; i < 3; i++) begin
            dead[i] = pick_used();
            delete_one(dead[i]);
        end
        for (int i = 0; i < 3; i++) begin
            apply_cmd(rand_cmd(op_trans_all, dead[i]));
            apply_cmd(rand_cmd(op_scale, dead[i]));
            apply_cmd(rand_cmd(op_rot_left, dead[i]));
        end
        foreach (noops[i]) begin
            run_cmd(rand_cmd(noops[i], pick_used()), rose, vld, rec);
            check_value($sformatf("busy on no-op %h", noops[i]), 160'(rose), 160'(0));
        end
        for (int i = 0; i < 32; i++) begin
            check_slot(i);
        end
        report_test(6, "free slots and no-ops");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
